// ==== logic/ooo_issue_config.svh ====
`ifndef OOO_ISSUE_CONFIG_SVH
`define OOO_ISSUE_CONFIG_SVH

// Reservation station depth
`define RS_ENTRIES 16

// Physical register file size
`define PHY_REGS 64

// Reorder buffer size, sets the ROB tag width
`define ROB_ENTRIES 16

// Dispatch age counter width
`define AGE_W 32

// Address and immediate width
`define XLEN 32

`endif

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

// RISC-V instruction fields as they travel through the issue stage
package rv_isa_pkg;

    // Major opcode, bits 6:0 of the encoding
    typedef logic [6:0] opcode_t;

    // Minor function fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Instruction address, also used for predicted branch targets
    typedef logic [`XLEN-1:0] xaddr_t;

    // Immediate after sign extension at decode
    typedef logic [`XLEN-1:0] imm_t;

endpackage

`default_nettype wire

// ==== logic/issue_pkg.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

// Types shared by the reservation station blocks
package issue_pkg;

    typedef logic [$clog2(`PHY_REGS)-1:0]    preg_t;
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_id_t;
    typedef logic [$clog2(`RS_ENTRIES)-1:0]  slot_t;
    // One extra bit so a full station (16) fits
    typedef logic [$clog2(`RS_ENTRIES):0]    count_t;
    typedef logic [`AGE_W-1:0]               age_t;

    // Renamed instruction payload
    typedef struct packed {
        rv_isa_pkg::xaddr_t  addr;
        rv_isa_pkg::opcode_t opcode;
        rv_isa_pkg::funct3_t funct3;
        rv_isa_pkg::funct7_t funct7;
        preg_t               rs1;
        preg_t               rs2;
        preg_t               rd;
        rv_isa_pkg::imm_t    imm;
        logic                predict_taken;
        rv_isa_pkg::xaddr_t  predict_target;
        rob_id_t             rob_id;
    } uop_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
    } dispatch_t;

    // One station slot, age is the dispatch order stamp
    typedef struct packed {
        logic valid;
        uop_t uop;
        age_t age;
    } rs_entry_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
    } issue_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } wb_t;

    // Slot handed back to the free list after issue
    typedef struct packed {
        logic  valid;
        slot_t slot;
    } release_t;

endpackage

`default_nettype wire

// ==== logic/prf_ready_table.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module prf_ready_table (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire issue_pkg::dispatch_t dispatch_0,
    input  wire issue_pkg::dispatch_t dispatch_1,
    input  wire issue_pkg::wb_t       wb,
    output logic [`PHY_REGS-1:0]      ready_bits
);

    logic [`PHY_REGS-1:0] ready_q;

    // All registers hold committed values out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q <= '1;
        end else begin
            if (wb.valid) begin
                ready_q[wb.preg] <= 1'b1;
            end
            // Clears come last so a new producer beats a stale writeback
            if (dispatch_0.valid) begin
                ready_q[dispatch_0.uop.rd] <= 1'b0;
            end
            if (dispatch_1.valid) begin
                ready_q[dispatch_1.uop.rd] <= 1'b0;
            end
        end
    end

    assign ready_bits = ready_q;

endmodule

`default_nettype wire

// ==== logic/rs_free_list.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module rs_free_list (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                flush,
    input  wire logic                alloc_0,
    input  wire logic                alloc_1,
    input  wire issue_pkg::release_t slot_release,
    output issue_pkg::slot_t         free_slot_0,
    output issue_pkg::slot_t         free_slot_1,
    output issue_pkg::count_t        free_count
);

    logic [`RS_ENTRIES-1:0] free_q;
    logic [`RS_ENTRIES-1:0] free_rest;
    issue_pkg::slot_t       first_free;
    issue_pkg::slot_t       second_free;
    issue_pkg::count_t      count_q;

    // Priority encoder where the lowest set bit wins
    function automatic issue_pkg::slot_t lowest_set(input logic [`RS_ENTRIES-1:0] vec);
        issue_pkg::slot_t idx;
        idx = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = issue_pkg::slot_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        first_free            = lowest_set(free_q);
        free_rest             = free_q;
        free_rest[first_free] = 1'b0;
        second_free           = lowest_set(free_rest);
    end

    assign free_slot_0 = first_free;
    // A lone dispatch on port 1 gets the lowest slot
    assign free_slot_1 = alloc_0 ? second_free : first_free;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            free_q  <= '1;
            count_q <= issue_pkg::count_t'(`RS_ENTRIES);
        end else if (flush) begin
            free_q  <= '1;
            count_q <= issue_pkg::count_t'(`RS_ENTRIES);
        end else begin
            if (alloc_0) begin
                free_q[free_slot_0] <= 1'b0;
            end
            if (alloc_1) begin
                free_q[free_slot_1] <= 1'b0;
            end
            // A released slot is busy and never collides with an allocation
            if (slot_release.valid) begin
                free_q[slot_release.slot] <= 1'b1;
            end
            count_q <= count_q
                     - issue_pkg::count_t'(alloc_0)
                     - issue_pkg::count_t'(alloc_1)
                     + issue_pkg::count_t'(slot_release.valid);
        end
    end

    assign free_count = count_q;

endmodule

`default_nettype wire

// ==== logic/rs_select.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module rs_select (
    input  wire issue_pkg::rs_entry_t [`RS_ENTRIES-1:0] entries,
    input  wire logic [`PHY_REGS-1:0]                   ready_bits,
    output issue_pkg::slot_t                            best_slot,
    output logic                                        best_valid
);

    localparam int LEVELS = $clog2(`RS_ENTRIES);

    // Oldest-first tree with the leaves at level 0
    always_comb begin
        logic             node_valid [0:LEVELS][0:`RS_ENTRIES-1];
        issue_pkg::slot_t node_slot  [0:LEVELS][0:`RS_ENTRIES-1];
        issue_pkg::age_t  node_age   [0:LEVELS][0:`RS_ENTRIES-1];
        logic             take_left;

        for (int l = 0; l <= LEVELS; l++) begin
            for (int n = 0; n < `RS_ENTRIES; n++) begin
                node_valid[l][n] = 1'b0;
                node_slot[l][n]  = '0;
                node_age[l][n]   = '0;
            end
        end

        // Candidate when both sources are ready
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            node_valid[0][i] = entries[i].valid
                             && ready_bits[entries[i].uop.rs1]
                             && ready_bits[entries[i].uop.rs2];
            node_slot[0][i]  = issue_pkg::slot_t'(i);
            node_age[0][i]   = entries[i].age;
        end

        for (int l = 1; l <= LEVELS; l++) begin
            for (int n = 0; n < (`RS_ENTRIES >> l); n++) begin
                // Ages are unique so a strict compare is enough
                take_left = node_valid[l-1][2*n]
                         && (!node_valid[l-1][2*n+1]
                             || node_age[l-1][2*n] < node_age[l-1][2*n+1]);
                node_valid[l][n] = node_valid[l-1][2*n] || node_valid[l-1][2*n+1];
                node_slot[l][n]  = take_left ? node_slot[l-1][2*n] : node_slot[l-1][2*n+1];
                node_age[l][n]   = take_left ? node_age[l-1][2*n] : node_age[l-1][2*n+1];
            end
        end

        best_valid = node_valid[LEVELS][0];
        best_slot  = node_slot[LEVELS][0];
    end

endmodule

`default_nettype wire

// ==== logic/rs_control.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module rs_control (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               flush,
    input  wire logic                               busy,
    input  wire issue_pkg::dispatch_t               dispatch_0,
    input  wire issue_pkg::dispatch_t               dispatch_1,
    input  wire issue_pkg::slot_t                   free_slot_0,
    input  wire issue_pkg::slot_t                   free_slot_1,
    input  wire issue_pkg::slot_t                   best_slot,
    input  wire logic                               best_valid,
    output issue_pkg::rs_entry_t [`RS_ENTRIES-1:0]  entries,
    output logic                                    alloc_0,
    output logic                                    alloc_1,
    output issue_pkg::release_t                     slot_release,
    output issue_pkg::issue_t                       issue
);

    logic [`RS_ENTRIES-1:0] valid_q;
    issue_pkg::uop_t        uop_q       [0:`RS_ENTRIES-1];
    issue_pkg::age_t        entry_age_q [0:`RS_ENTRIES-1];
    issue_pkg::age_t        age_ctr;
    issue_pkg::age_t        age_1;
    logic                   fire;

    // Dispatches in a flush cycle are dropped
    assign alloc_0 = dispatch_0.valid && !flush;
    assign alloc_1 = dispatch_1.valid && !flush;

    // Port 1 is younger when both ports dispatch
    assign age_1 = alloc_0 ? age_ctr + issue_pkg::age_t'(1) : age_ctr;

    // Issue straight from the selection unless busy or flush holds it off
    assign fire = best_valid && !busy && !flush;

    assign issue.valid        = fire;
    assign issue.uop          = uop_q[best_slot];
    assign slot_release.valid = fire;
    assign slot_release.slot  = best_slot;

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            entries[i].valid = valid_q[i];
            entries[i].uop   = uop_q[i];
            entries[i].age   = entry_age_q[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            age_ctr <= '0;
        end else if (flush) begin
            valid_q <= '0;
            age_ctr <= '0;
        end else begin
            // Issued slot is never one of the offered free slots
            if (fire) begin
                valid_q[best_slot] <= 1'b0;
            end
            if (alloc_0) begin
                valid_q[free_slot_0] <= 1'b1;
            end
            if (alloc_1) begin
                valid_q[free_slot_1] <= 1'b1;
            end
            age_ctr <= age_ctr
                     + issue_pkg::age_t'(alloc_0)
                     + issue_pkg::age_t'(alloc_1);
        end
    end

    // Payload and age storage
    always_ff @(posedge clk) begin
        if (alloc_0) begin
            uop_q[free_slot_0]       <= dispatch_0.uop;
            entry_age_q[free_slot_0] <= age_ctr;
        end
        if (alloc_1) begin
            uop_q[free_slot_1]       <= dispatch_1.uop;
            entry_age_q[free_slot_1] <= age_1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ooo_issue.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module ooo_issue (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 flush,
    input  wire logic                 busy,
    input  wire issue_pkg::dispatch_t dispatch_0,
    input  wire issue_pkg::dispatch_t dispatch_1,
    input  wire issue_pkg::wb_t       wb,
    output issue_pkg::issue_t         issue,
    output issue_pkg::count_t         free_count
);

    logic [`PHY_REGS-1:0]                   ready_bits;
    issue_pkg::rs_entry_t [`RS_ENTRIES-1:0] entries;
    issue_pkg::slot_t                       best_slot;
    logic                                   best_valid;
    issue_pkg::slot_t                       free_slot_0;
    issue_pkg::slot_t                       free_slot_1;
    logic                                   alloc_0;
    logic                                   alloc_1;
    issue_pkg::release_t                    slot_release;

    prf_ready_table u_ready_table (
        .clk        (clk),
        .rst        (rst),
        .dispatch_0 (dispatch_0),
        .dispatch_1 (dispatch_1),
        .wb         (wb),
        .ready_bits (ready_bits)
    );

    rs_free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc_0      (alloc_0),
        .alloc_1      (alloc_1),
        .slot_release (slot_release),
        .free_slot_0  (free_slot_0),
        .free_slot_1  (free_slot_1),
        .free_count   (free_count)
    );

    rs_select u_select (
        .entries    (entries),
        .ready_bits (ready_bits),
        .best_slot  (best_slot),
        .best_valid (best_valid)
    );

    rs_control u_control (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .busy         (busy),
        .dispatch_0   (dispatch_0),
        .dispatch_1   (dispatch_1),
        .free_slot_0  (free_slot_0),
        .free_slot_1  (free_slot_1),
        .best_slot    (best_slot),
        .best_valid   (best_valid),
        .entries      (entries),
        .alloc_0      (alloc_0),
        .alloc_1      (alloc_1),
        .slot_release (slot_release),
        .issue        (issue)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);

    // Half of the 10-unit period
    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/ooo_issue_assertions.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module ooo_issue_assertions (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   flush,
    input  wire logic                                   busy,
    input  wire issue_pkg::issue_t                      issue,
    input  wire issue_pkg::count_t                      free_count,
    input  wire issue_pkg::slot_t                       best_slot,
    input  wire issue_pkg::rs_entry_t [`RS_ENTRIES-1:0] entries
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    no_issue_when_held: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> !busy && !flush)
    else begin
        fail_count++;
        $error("issue.valid high while busy or flush is high");
    end

    free_count_bound: assert property (@(posedge clk) disable iff (rst)
        free_count <= issue_pkg::count_t'(`RS_ENTRIES))
    else begin
        fail_count++;
        $error("free_count above the station depth");
    end

    // Issued slot must be empty one edge later
    issued_slot_cleared: assert property (@(posedge clk) disable iff (rst)
        issue.valid |=> !entries[$past(best_slot)].valid)
    else begin
        fail_count++;
        $error("issued entry still valid after the release edge");
    end

endmodule

bind ooo_issue ooo_issue_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .busy       (busy),
    .issue      (issue),
    .free_count (free_count),
    .best_slot  (best_slot),
    .entries    (entries)
);

`default_nettype wire

// ==== tb/ooo_issue_tb.sv ====
`default_nettype none

`include "ooo_issue_config.svh"

module ooo_issue_tb;

    localparam int RUN_CYCLES  = 400;
    localparam int FLUSH_CYCLE = 200;
    localparam int FLUSH_HOLD  = 4;
    localparam int DRAIN_LIMIT = 300;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 busy;
    issue_pkg::dispatch_t dispatch_0;
    issue_pkg::dispatch_t dispatch_1;
    issue_pkg::wb_t       wb;
    issue_pkg::issue_t    issue;
    issue_pkg::count_t    free_count;

    // Reference model with the live queue kept in dispatch order
    logic [`PHY_REGS-1:0] ready_m;
    issue_pkg::uop_t      live_uop [$];
    int                   live_seq [$];
    int                   next_seq;
    int                   exp_free;
    int                   errors;
    int                   seed = 32'h1faf;

    tb_clock u_clock (.clk(clk));

    ooo_issue u_ooo_issue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .busy       (busy),
        .dispatch_0 (dispatch_0),
        .dispatch_1 (dispatch_1),
        .wb         (wb),
        .issue      (issue),
        .free_count (free_count)
    );

    function automatic issue_pkg::uop_t random_uop();
        issue_pkg::uop_t u;
        u.addr           = rv_isa_pkg::xaddr_t'($random(seed));
        u.opcode         = rv_isa_pkg::opcode_t'($random(seed));
        u.funct3         = rv_isa_pkg::funct3_t'($random(seed));
        u.funct7         = rv_isa_pkg::funct7_t'($random(seed));
        u.rs1            = issue_pkg::preg_t'($random(seed));
        u.rs2            = issue_pkg::preg_t'($random(seed));
        u.rd             = issue_pkg::preg_t'($random(seed));
        u.imm            = rv_isa_pkg::imm_t'($random(seed));
        u.predict_taken  = 1'($random(seed));
        u.predict_target = rv_isa_pkg::xaddr_t'($random(seed));
        u.rob_id         = issue_pkg::rob_id_t'($random(seed));
        return u;
    endfunction

    // Writes back some register that is still pending in the model
    function automatic issue_pkg::wb_t pending_writeback();
        issue_pkg::wb_t w;
        int             start;
        w     = '0;
        start = $random(seed) & (`PHY_REGS - 1);
        for (int k = 0; k < `PHY_REGS; k++) begin
            if (!w.valid && !ready_m[(start + k) % `PHY_REGS]) begin
                w.valid = 1'b1;
                w.preg  = issue_pkg::preg_t'((start + k) % `PHY_REGS);
            end
        end
        return w;
    endfunction

    function automatic int oldest_ready();
        for (int i = 0; i < live_uop.size(); i++) begin
            if (ready_m[live_uop[i].rs1] && ready_m[live_uop[i].rs2]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // One clock that drives at the rising edge, checks at the falling edge and steps the model
    task automatic run_cycle(input issue_pkg::dispatch_t d0, input issue_pkg::dispatch_t d1,
                             input issue_pkg::wb_t w, input logic fl, input logic bz);
        int   pick;
        logic exp_valid;
        @(posedge clk);
        dispatch_0 <= d0;
        dispatch_1 <= d1;
        wb         <= w;
        flush      <= fl;
        busy       <= bz;
        @(negedge clk);
        pick      = oldest_ready();
        exp_valid = (pick >= 0) && !bz && !fl;
        assert (issue.valid == exp_valid) else begin
            errors++;
            $display("[FAIL] %0t issue.valid expected %0b actual %0b",
                     $time, exp_valid, issue.valid);
        end
        assert (int'(free_count) == exp_free) else begin
            errors++;
            $display("[FAIL] %0t free_count expected %0d actual %0d",
                     $time, exp_free, free_count);
        end
        if (exp_valid) begin
            assert (!issue.valid || issue.uop == live_uop[pick]) else begin
                errors++;
                $display("[FAIL] %0t issue.uop (seq %0d) expected %h actual %h",
                         $time, live_seq[pick], live_uop[pick], issue.uop);
            end
            live_uop.delete(pick);
            live_seq.delete(pick);
            exp_free++;
        end
        // Ready table ignores flush and a dispatch clear beats a writeback
        if (w.valid) ready_m[w.preg] = 1'b1;
        if (d0.valid) ready_m[d0.uop.rd] = 1'b0;
        if (d1.valid) ready_m[d1.uop.rd] = 1'b0;
        if (fl) begin
            live_uop.delete();
            live_seq.delete();
            exp_free = `RS_ENTRIES;
        end else begin
            if (d0.valid) begin
                live_uop.push_back(d0.uop);
                live_seq.push_back(next_seq++);
                exp_free--;
            end
            if (d1.valid) begin
                live_uop.push_back(d1.uop);
                live_seq.push_back(next_seq++);
                exp_free--;
            end
        end
    endtask

    initial begin
        issue_pkg::dispatch_t d0;
        issue_pkg::dispatch_t d1;
        issue_pkg::wb_t       w;
        logic                 fl;
        logic                 hold;
        int                   room;
        int                   busy_left;
        int                   drain;
        int                   assert_errors;

        rst        = 1'b1;
        flush      = 1'b0;
        busy       = 1'b0;
        dispatch_0 = '0;
        dispatch_1 = '0;
        wb         = '0;
        ready_m    = '1;
        next_seq   = 0;
        exp_free   = `RS_ENTRIES;
        errors     = 0;
        busy_left  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            fl   = (cyc == FLUSH_CYCLE);
            // Keep entries waiting in the station when the flush arrives
            hold = (cyc >= FLUSH_CYCLE - FLUSH_HOLD) && (cyc < FLUSH_CYCLE);
            room = exp_free;
            d0   = '0;
            d1   = '0;
            if (!fl && room > 0 && (hold || ($random(seed) & 1))) begin
                d0 = {1'b1, random_uop()};
                room--;
            end
            if (!fl && room > 0 && ($random(seed) & 1)) begin
                d1 = {1'b1, random_uop()};
            end
            w = ($random(seed) & 1) ? pending_writeback() : '0;
            // Busy windows of 3 to 10 cycles
            if (busy_left > 0) begin
                busy_left--;
            end else if (($random(seed) & 15) == 0) begin
                busy_left = 3 + ($random(seed) & 7);
            end
            run_cycle(d0, d1, w, fl, hold || busy_left > 0);
        end

        drain = 0;
        while (live_uop.size() > 0 && drain < DRAIN_LIMIT) begin
            run_cycle('0, '0, pending_writeback(), 1'b0, 1'b0);
            drain++;
        end
        if (live_uop.size() > 0) begin
            errors++;
            $display("Timeout: %0d dispatched instructions never issued", live_uop.size());
        end
        run_cycle('0, '0, '0, 1'b0, 1'b0);

        assert_errors = u_ooo_issue.u_assertions.fail_count;
        $display("Run finished: %0d check errors, %0d assertion errors",
                 errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ooo_issue.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/issue_pkg.sv
logic/prf_ready_table.sv
logic/rs_free_list.sv
logic/rs_select.sv
logic/rs_control.sv
logic/ooo_issue.sv
tb/tb_clock.sv
tb/ooo_issue_assertions.sv
tb/ooo_issue_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ooo_issue_tb
FILELIST = ooo_issue.f
BUILD    = obj_dir
RUN_ARGS = +verilator+error+limit+100
LOG      = sim.log
FAIL_MSG = Errors found
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(BUILD) $(LOG)
